// File: load_align.sv
/* load data aligner: byte lane shift, then sign or zero extension by size */

`timescale 1ns/1ps

module load_align (
	input  logic [mem_ctrl_pkg::DWID-1:0] rdata_i,
	input  logic [2:0]                    lane_i,
	input  mem_ctrl_pkg::mem_size_e       size_i,
	input  logic                          zext_i,
	output logic [mem_ctrl_pkg::DWID-1:0] res_o
);

	import mem_ctrl_pkg::*;

	logic [DWID-1:0] shifted;
	logic            fill;

	// move the addressed lane down to bit 0
	assign shifted = rdata_i >> {lane_i, 3'b000};

	always_comb begin
		fill = 1'b0;
		case (size_i)
		SZ_B: begin
			fill  = shifted[7] & ~zext_i;
			res_o = {{(DWID-8){fill}}, shifted[7:0]};
		end
		SZ_W: begin
			fill  = shifted[15] & ~zext_i;
			res_o = {{(DWID-16){fill}}, shifted[15:0]};
		end
		SZ_T: begin
			fill  = shifted[31] & ~zext_i;
			res_o = {{(DWID-32){fill}}, shifted[31:0]};
		end
		default: begin
			res_o = shifted;  // octa, nothing to extend
		end
		endcase
	end

endmodule

// File: mem_ctrl_assertions.sv
/* bound protocol checks on the sequencer bus and queue handshakes */

`timescale 1ns/1ps

module mem_ctrl_assertions (
	input logic                   clk,
	input logic                   rst,
	input mem_ctrl_pkg::bus_req_t bus_i,
	input logic                   req_empty_i,
	input logic                   req_pop_i,
	input logic                   resp_full_i,
	input logic                   resp_push_i
);

	int unsigned fail_cnt = 0;  // number of failed checks

	// ==============================
	// bus side
	// ==============================
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
		bus_i.stb |-> bus_i.cyc)
	else begin
		fail_cnt++;
		$error("stb high while cyc is low");
	end

	a_sel_idle: assert property (@(posedge clk) disable iff (rst)
		!bus_i.cyc |-> bus_i.sel == '0)
	else begin
		fail_cnt++;
		$error("byte selects set outside a bus cycle");
	end

	a_we_in_cyc: assert property (@(posedge clk) disable iff (rst)
		bus_i.we |-> bus_i.cyc)
	else begin
		fail_cnt++;
		$error("we high outside a bus cycle");
	end

	// ==============================
	// queue side
	// ==============================
	a_push_room: assert property (@(posedge clk) disable iff (rst)
		!(resp_push_i && resp_full_i))
	else begin
		fail_cnt++;
		$error("response pushed into a full queue");
	end

	a_pop_data: assert property (@(posedge clk) disable iff (rst)
		!(req_pop_i && req_empty_i))
	else begin
		fail_cnt++;
		$error("request popped from an empty queue");
	end

endmodule

bind mem_seq mem_ctrl_assertions u_asrt (
	.clk         (clk),
	.rst         (rst),
	.bus_i       (bus_o),
	.req_empty_i (req_empty_i),
	.req_pop_i   (req_pop_o),
	.resp_full_i (resp_full_i),
	.resp_push_i (resp_push_o)
);

// File: mem_ctrl_pkg.sv
/* shared widths, command and size encodings, fault codes,
   request/response/bus structs and the request payload union */

package mem_ctrl_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int AWID  = 32;       // address
	localparam int DWID  = 64;       // bus word
	localparam int TID_W = 4;        // transaction id
	localparam int SEL_W = DWID / 8; // one select per byte lane

	// ==============================
	// encodings
	// ==============================
	typedef enum logic [1:0] {
		FN_LOAD   = 2'd0,  // sign extended
		FN_LOADZ  = 2'd1,  // zero extended
		FN_STORE  = 2'd2,
		FN_SETSEG = 2'd3   // load base/limit from data word
	} mem_func_e;

	typedef enum logic [1:0] {
		SZ_B = 2'd0,  // byte
		SZ_W = 2'd1,  // wyde
		SZ_T = 2'd2,  // tetra
		SZ_O = 2'd3   // octa
	} mem_size_e;

	typedef enum logic [7:0] {
		FLT_NONE = 8'h00,
		FLT_SGB  = 8'h31  // segment bound
	} fault_e;

	// ==============================
	// structs
	// ==============================

	// segment descriptor, base in the upper half of the word
	typedef struct packed {
		logic [AWID-1:0] base;
		logic [AWID-1:0] limit;
	} seg_desc_t;

	// request data word: store data, or a descriptor for SETSEG
	typedef union packed {
		logic [DWID-1:0] sdat;
		seg_desc_t       desc;
	} req_payload_u;

	typedef struct packed {
		logic [TID_W-1:0] tid;
		mem_func_e        func;
		mem_size_e        size;
		logic [AWID-1:0]  adr;      // segment offset
		req_payload_u     payload;
	} mem_req_t;

	typedef struct packed {
		logic [TID_W-1:0] tid;
		fault_e           cause;
		logic [DWID-1:0]  res;
		logic [AWID-1:0]  bad_addr;
	} mem_resp_t;

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [SEL_W-1:0] sel;
		logic [AWID-1:0]  adr;
		logic [DWID-1:0]  dat;
	} bus_req_t;

endpackage

// File: mem_ctrl_top.sv
/* memory controller top: request queue, sequencer, response queue */

`timescale 1ns/1ps

module mem_ctrl_top #(
	parameter int REQ_DEPTH  = 4,
	parameter int RESP_DEPTH = 4
) (
	input  logic                          clk,
	input  logic                          rst,
	input  mem_ctrl_pkg::mem_req_t        req_i,
	input  logic                          req_wr_i,
	output logic                          req_full_o,
	output mem_ctrl_pkg::mem_resp_t       resp_o,
	output logic                          resp_valid_o,
	input  logic                          resp_rd_i,
	output mem_ctrl_pkg::bus_req_t        bus_o,
	input  logic                          ack_i,
	input  logic [mem_ctrl_pkg::DWID-1:0] dat_i
);

	import mem_ctrl_pkg::*;

	mem_req_t  req_head;    // head of request queue
	logic      req_empty;
	logic      req_pop;
	mem_resp_t resp_new;
	logic      resp_push;
	logic      resp_full;
	logic      resp_empty;

	assign resp_valid_o = ~resp_empty;

	req_fifo #(
		.DEPTH (REQ_DEPTH),
		.WIDTH ($bits(mem_req_t))
	) u_req_q (
		.clk     (clk),
		.rst     (rst),
		.wr_i    (req_wr_i),
		.din_i   (req_i),
		.rd_i    (req_pop),
		.dout_o  (req_head),
		.empty_o (req_empty),
		.full_o  (req_full_o)
	);

	mem_seq u_seq (
		.clk         (clk),
		.rst         (rst),
		.req_i       (req_head),
		.req_empty_i (req_empty),
		.req_pop_o   (req_pop),
		.resp_o      (resp_new),
		.resp_push_o (resp_push),
		.resp_full_i (resp_full),
		.bus_o       (bus_o),
		.ack_i       (ack_i),
		.dat_i       (dat_i)
	);

	req_fifo #(
		.DEPTH (RESP_DEPTH),
		.WIDTH ($bits(mem_resp_t))
	) u_resp_q (
		.clk     (clk),
		.rst     (rst),
		.wr_i    (resp_push),
		.din_i   (resp_new),
		.rd_i    (resp_rd_i),
		.dout_o  (resp_o),
		.empty_o (resp_empty),
		.full_o  (resp_full)
	);

endmodule

// File: mem_seq.sv
/* access sequencer: descriptor register, limit check, relocation,
   byte-lane selects, single-beat bus cycle and response build */

`timescale 1ns/1ps

module mem_seq (
	input  logic                          clk,
	input  logic                          rst,
	input  mem_ctrl_pkg::mem_req_t        req_i,
	input  logic                          req_empty_i,
	output logic                          req_pop_o,
	output mem_ctrl_pkg::mem_resp_t       resp_o,
	output logic                          resp_push_o,
	input  logic                          resp_full_i,
	output mem_ctrl_pkg::bus_req_t        bus_o,
	input  logic                          ack_i,
	input  logic [mem_ctrl_pkg::DWID-1:0] dat_i
);

	import mem_ctrl_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CAPTURE,
		ST_ACCESS,
		ST_RESPOND
	} state_e;

	state_e           state;
	mem_req_t         req_r;      // request being served
	seg_desc_t        desc_r;
	logic             flt_r;      // limit fault on this request
	logic             cyc_r;
	logic             stb_r;
	logic             we_r;
	logic [SEL_W-1:0] sel_r;
	logic [AWID-1:0]  adr_r;
	logic [DWID-1:0]  dat_r;
	logic [DWID-1:0]  rdata_r;    // word captured at ack

	logic [2:0]       lo_mask;
	logic [SEL_W-1:0] sz_sel;
	logic [AWID-1:0]  reloc;
	logic [AWID-1:0]  phys;
	logic [2:0]       lane;
	logic             over_lim;
	logic             is_load;
	logic [DWID-1:0]  ld_res;

	// ==============================
	// address path
	// ==============================
	always_comb begin
		case (req_r.size)
		SZ_B: begin
			lo_mask = 3'b000;
			sz_sel  = 8'h01;
		end
		SZ_W: begin
			lo_mask = 3'b001;
			sz_sel  = 8'h03;
		end
		SZ_T: begin
			lo_mask = 3'b011;
			sz_sel  = 8'h0f;
		end
		default: begin
			lo_mask = 3'b111;
			sz_sel  = 8'hff;
		end
		endcase
	end

	assign reloc    = desc_r.base + req_r.adr;
	assign phys     = {reloc[AWID-1:3], reloc[2:0] & ~lo_mask};  // size aligned
	assign lane     = phys[2:0];
	assign over_lim = req_r.adr > desc_r.limit;
	assign is_load  = (req_r.func == FN_LOAD) || (req_r.func == FN_LOADZ);

	assign req_pop_o   = (state == ST_IDLE) && !req_empty_i;
	assign resp_push_o = (state == ST_RESPOND) && !resp_full_i;

	// ==============================
	// sequencer FSM
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ST_IDLE;
			desc_r <= '{base: '0, limit: '1};
			flt_r  <= 1'b0;
			cyc_r  <= 1'b0;
			stb_r  <= 1'b0;
			we_r   <= 1'b0;
			sel_r  <= '0;
		end else begin
			case (state)
			ST_IDLE:
				if (req_pop_o)
					state <= ST_CAPTURE;
			ST_CAPTURE: begin
				flt_r <= 1'b0;
				if (req_r.func == FN_SETSEG) begin
					desc_r <= req_r.payload.desc;
					state  <= ST_RESPOND;
				end else if (over_lim) begin
					flt_r <= 1'b1;   // no bus cycle
					state <= ST_RESPOND;
				end else begin
					cyc_r <= 1'b1;
					stb_r <= 1'b1;
					we_r  <= (req_r.func == FN_STORE);
					sel_r <= sz_sel << lane;
					state <= ST_ACCESS;
				end
			end
			ST_ACCESS:
				if (ack_i) begin
					cyc_r <= 1'b0;
					stb_r <= 1'b0;
					we_r  <= 1'b0;
					sel_r <= '0;
					state <= ST_RESPOND;
				end
			ST_RESPOND:
				if (!resp_full_i)
					state <= ST_IDLE;  // else hold for room
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (req_pop_o)
			req_r <= req_i;
		if (state == ST_CAPTURE) begin
			adr_r <= phys;
			dat_r <= req_r.payload.sdat << {lane, 3'b000};  // store data to its lane
		end
		if (state == ST_ACCESS && ack_i)
			rdata_r <= dat_i;
	end

	assign bus_o = '{cyc: cyc_r, stb: stb_r, we: we_r, sel: sel_r, adr: adr_r, dat: dat_r};

	load_align u_align (
		.rdata_i (rdata_r),
		.lane_i  (adr_r[2:0]),
		.size_i  (req_r.size),
		.zext_i  (req_r.func == FN_LOADZ),
		.res_o   (ld_res)
	);

	// response, stores and SETSEG return zero
	always_comb begin
		resp_o.tid      = req_r.tid;
		resp_o.cause    = flt_r ? FLT_SGB : FLT_NONE;
		resp_o.res      = (is_load && !flt_r) ? ld_res : '0;
		resp_o.bad_addr = flt_r ? req_r.adr : '0;
	end

endmodule

// File: req_fifo.sv
/* synchronous first-word-fall-through queue, register array with count */

`timescale 1ns/1ps

module req_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_i,
	input  logic [WIDTH-1:0] din_i,
	input  logic             rd_i,
	output logic [WIDTH-1:0] dout_o,
	output logic             empty_o,
	output logic             full_o
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wr_ptr;
	logic [PW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_wr;
	logic             do_rd;

	// pointer advance with wrap at DEPTH
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		if (p == PW'(DEPTH - 1))
			next_ptr = '0;
		else
			next_ptr = p + 1'b1;
	endfunction

	assign do_wr   = wr_i && !full_o;   // full write dropped
	assign do_rd   = rd_i && !empty_o;
	assign empty_o = (count == '0);
	assign full_o  = (count == CW'(DEPTH));
	assign dout_o  = mem[rd_ptr];       // head shows at once

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_wr, do_rd})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the fail message in the log
verilator --binary --timing --top-module tb_mem_ctrl -f sim.f -o sim_mem_ctrl \
	|| { echo "build failed"; exit 1; }
./obj_dir/sim_mem_ctrl +verilator+error+limit+100 > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: sim.f
mem_ctrl_pkg.sv
req_fifo.sv
load_align.sv
mem_seq.sv
mem_ctrl_top.sv
mem_ctrl_assertions.sv
tb_mem_ctrl.sv

// File: tb_mem_ctrl.sv
/* testbench for mem_ctrl_top with clock, bus memory model, directed and
   random stimulus, reference model and compare tasks */

`timescale 1ns/1ps

module tb_mem_ctrl;

	import mem_ctrl_pkg::*;

	localparam int N_RAND     = 400;
	localparam int N_DIRECTED = 27;
	localparam int TIMEOUT    = (N_RAND + N_DIRECTED) * 12 + 200;

	logic                clk;
	logic                rst;
	mem_req_t            req_i;
	logic                req_wr_i;
	logic                req_full_o;
	mem_resp_t           resp_o;
	logic                resp_valid_o;
	logic                resp_rd_i;
	bus_req_t            bus_o;
	logic                ack_i;
	logic [DWID-1:0]     dat_i;

	logic [7:0]          bus_mem [logic [31:0]];  // memory behind the bus
	logic [7:0]          ref_mem [logic [31:0]];  // model copy
	seg_desc_t           m_desc;
	mem_resp_t           exp_resp [$];
	string               exp_name [$];
	bus_req_t            exp_bus [$];
	string               exp_bus_name [$];
	string               cur_test;
	logic [TID_W-1:0]    next_tid;
	logic                rd_hold;
	logic                rd_random;
	int                  n_err;
	int                  n_other;
	int                  cycles;

	mem_ctrl_top #(.REQ_DEPTH(4), .RESP_DEPTH(4)) dut0 (
		.clk          (clk),
		.rst          (rst),
		.req_i        (req_i),
		.req_wr_i     (req_wr_i),
		.req_full_o   (req_full_o),
		.resp_o       (resp_o),
		.resp_valid_o (resp_valid_o),
		.resp_rd_i    (resp_rd_i),
		.bus_o        (bus_o),
		.ack_i        (ack_i),
		.dat_i        (dat_i)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// memory helpers
	// ==============================
	function automatic logic [7:0] fill_byte(input logic [31:0] a);
		return 8'h5a + (a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]);  // bytes never written
	endfunction

	function automatic logic [7:0] bus_byte(input logic [31:0] a);
		return bus_mem.exists(a) ? bus_mem[a] : fill_byte(a);
	endfunction

	function automatic logic [7:0] ref_byte(input logic [31:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
	endfunction

	function automatic logic [DWID-1:0] read_word(input logic [31:0] a);
		logic [DWID-1:0] w;
		for (int k = 0; k < 8; k++)
			w[8*k +: 8] = bus_byte({a[31:3], 3'(k)});
		return w;
	endfunction

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
		if (act !== exp) begin
			n_err++;
			$write("error %s: expected tid %0d cause %02h res %016h bad %08h",
				name, exp.tid, exp.cause, exp.res, exp.bad_addr);
			$display(", actual tid %0d cause %02h res %016h bad %08h",
				act.tid, act.cause, act.res, act.bad_addr);
		end
	endtask

	task automatic check_bus(input string name, input bus_req_t exp, input bus_req_t act);
		bus_req_t cmp;
		cmp = act;
		if (!exp.we)
			cmp.dat = exp.dat;  // data lines only matter on a write
		if (cmp !== exp) begin
			n_err++;
			$write("error %s: expected adr %08h sel %02h we %0b dat %016h",
				name, exp.adr, exp.sel, exp.we, exp.dat);
			$display(", actual adr %08h sel %02h we %0b dat %016h",
				act.adr, act.sel, act.we, act.dat);
		end
	endtask

	// ==============================
	// reference model
	// ==============================
	task automatic model_req(input mem_req_t r);
		mem_resp_t       rsp;
		bus_req_t        bus;
		logic [31:0]     phys;
		logic [DWID-1:0] word;
		int              nb;
		int              lane;
		rsp = '{tid: r.tid, cause: FLT_NONE, res: '0, bad_addr: '0};
		if (r.func == FN_SETSEG) begin
			m_desc = r.payload.desc;
		end else if (r.adr > m_desc.limit) begin
			rsp.cause    = FLT_SGB;   // no bus cycle expected
			rsp.bad_addr = r.adr;
		end else begin
			nb   = 1 << r.size;
			phys = (m_desc.base + r.adr) & ~(32'(nb) - 32'd1);
			lane = int'(phys[2:0]);
			bus  = '{cyc: 1'b1, stb: 1'b1, we: (r.func == FN_STORE), sel: '0,
				adr: phys, dat: '0};
			bus.sel = 8'(((1 << nb) - 1) << lane);
			bus.dat = r.payload.sdat << (8 * lane);
			if (r.func == FN_STORE) begin
				for (int i = 0; i < nb; i++)
					ref_mem[phys + 32'(i)] = r.payload.sdat[8*i +: 8];
			end else begin
				word = '0;
				for (int i = 0; i < nb; i++)
					word[8*i +: 8] = ref_byte(phys + 32'(i));
				if (r.func == FN_LOAD && word[8*nb-1])
					word = word | (~64'd0 << (8 * nb));  // sign fill
				rsp.res = word;
			end
			exp_bus.push_back(bus);
			exp_bus_name.push_back(cur_test);
		end
		exp_resp.push_back(rsp);
		exp_name.push_back(cur_test);
	endtask

	// ==============================
	// stimulus
	// ==============================
	task automatic send_req(input mem_func_e f, input mem_size_e s, input logic [31:0] adr,
	                        input logic [DWID-1:0] data);
		mem_req_t r;
		r.tid          = next_tid;
		r.func         = f;
		r.size         = s;
		r.adr          = adr;
		r.payload.sdat = data;
		next_tid       = next_tid + 4'd1;
		while (req_full_o) begin
			@(posedge clk);
			#1;
		end
		req_i    = r;
		req_wr_i = 1'b1;
		model_req(r);
		@(posedge clk);
		#1;
		req_wr_i = 1'b0;
	endtask

	task automatic set_seg(input logic [31:0] base, input logic [31:0] limit);
		seg_desc_t d;
		d.base  = base;
		d.limit = limit;
		send_req(FN_SETSEG, SZ_O, '0, d);
	endtask

	task automatic wait_drain();
		while (exp_resp.size() != 0)
			@(posedge clk);
		#1;
	endtask

	// response side pops when told to
	initial begin
		resp_rd_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (rd_hold)
				resp_rd_i = 1'b0;
			else if (rd_random)
				resp_rd_i = (($urandom % 4) != 0);
			else
				resp_rd_i = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!rst && resp_valid_o && resp_rd_i) begin
			if (exp_resp.size() == 0) begin
				n_other++;
				$display("response with tid %0d arrived but none was expected", resp_o.tid);
			end else begin
				check_resp(exp_name.pop_front(), exp_resp.pop_front(), resp_o);
			end
		end
	end

	// bus slave acks after 0 to 3 cycles
	initial begin : bus_model
		int delay_left;
		ack_i      = 1'b0;
		dat_i      = '0;
		delay_left = -1;
		forever begin
			@(posedge clk);
			#1;
			if (ack_i) begin
				ack_i = 1'b0;  // taken on the last edge
			end else if (!rst && bus_o.cyc && bus_o.stb) begin
				if (delay_left < 0)
					delay_left = int'($urandom % 4);
				if (delay_left == 0) begin
					ack_i = 1'b1;
					dat_i = read_word(bus_o.adr);
				end
				delay_left = delay_left - 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && bus_o.cyc && bus_o.stb && ack_i) begin
			if (exp_bus.size() == 0) begin
				n_other++;
				$display("bus cycle at %08h started but none was expected", bus_o.adr);
			end else begin
				check_bus(exp_bus_name.pop_front(), exp_bus.pop_front(), bus_o);
			end
			if (bus_o.we)
				for (int k = 0; k < 8; k++)
					if (bus_o.sel[k])
						bus_mem[{bus_o.adr[31:3], 3'(k)}] = bus_o.dat[8*k +: 8];
		end
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d responses outstanding",
			cycles, exp_resp.size());
		$display("Done: errors found");
		$finish;
	end

	// ==============================
	// test sequence
	// ==============================
	initial begin
		int              wait_n;
		int              pick;
		mem_size_e       sz;
		logic [DWID-1:0] data;
		void'($urandom(32'hb15f));
		rst       = 1'b1;
		req_i     = '0;
		req_wr_i  = 1'b0;
		rd_hold   = 1'b0;
		rd_random = 1'b0;
		next_tid  = '0;
		n_err     = 0;
		n_other   = 0;
		m_desc    = '{base: '0, limit: '1};
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		cur_test = "store_load";
		for (int s = 0; s < 4; s++) begin
			send_req(FN_STORE, mem_size_e'(s), 32'h105 + 32'(s * 16), 64'h0123_4567_89ab_cdef);
			send_req(FN_LOAD, mem_size_e'(s), 32'h105 + 32'(s * 16), '0);
		end
		wait_drain();

		cur_test = "loadz";
		send_req(FN_STORE, SZ_B, 32'h151, 64'h9c);
		send_req(FN_LOADZ, SZ_B, 32'h151, '0);
		wait_drain();

		cur_test = "seg_limit";
		set_seg(32'h0, 32'h40);
		send_req(FN_LOAD, SZ_T, 32'h40, '0);     // at the limit is still allowed
		send_req(FN_LOAD, SZ_B, 32'h41, '0);
		send_req(FN_STORE, SZ_O, 32'h1000, '1);
		wait_drain();

		cur_test = "relocation";
		set_seg(32'h2000, 32'hfff);
		send_req(FN_STORE, SZ_T, 32'h24, 64'h1234_5678_a5a5_5a5a);
		set_seg(32'h0, 32'hffff_ffff);
		send_req(FN_LOAD, SZ_T, 32'h2024, '0);   // same physical word
		wait_drain();

		cur_test = "backpressure";
		rd_hold = 1'b1;
		for (int i = 0; i < 9; i++)
			send_req(FN_LOAD, SZ_O, 32'h200 + 32'(i * 8), '0);
		wait_n = 0;
		while (!req_full_o && wait_n < 100) begin
			@(posedge clk);
			#1;
			wait_n++;
		end
		if (!req_full_o) begin
			n_other++;
			$display("request queue never filled while responses were held back");
		end
		rd_hold = 1'b0;
		wait_drain();

		cur_test  = "random";
		rd_random = 1'b1;
		for (int i = 0; i < N_RAND; i++) begin
			pick = int'($urandom % 16);
			sz   = mem_size_e'(2'($urandom % 4));
			data = {$urandom, $urandom};
			if (pick == 0)
				set_seg(32'($urandom % 512),
					(($urandom % 2) == 0) ? 32'hffff_ffff : 32'h100 + 32'($urandom % 32'h300));
			else if (pick < 6)
				send_req(FN_STORE, sz, 32'($urandom % 32'h400), data);
			else if (pick < 12)
				send_req(FN_LOAD, sz, 32'($urandom % 32'h400), data);
			else
				send_req(FN_LOADZ, sz, 32'($urandom % 32'h400), data);
		end
		wait_drain();

		if (exp_bus.size() != 0) begin
			n_other++;
			$display("%0d expected bus cycles never happened", exp_bus.size());
		end
		if (dut0.u_seq.u_asrt.fail_cnt != 0) begin
			n_other++;
			$display("%0d protocol assertions failed", dut0.u_seq.u_asrt.fail_cnt);
		end
		$display("value errors: %0d, other errors: %0d", n_err, n_other);
		if (n_err == 0 && n_other == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
